//--- compile.f
+incdir+verilog
verilog/if_pkg.sv
verilog/pc_select.sv
verilog/wb_fetch.sv
verilog/fetch_buffer.sv
verilog/if_id_reg.sv
verilog/if_stage.sv
bench/wb_mem_model.sv
bench/tb_if_stage.sv

//--- bench/tb_if_stage.sv
//////////////////////////////
// fetch stage testbench
// redirect table, stall rolls, watchdog
//////////////////////////////
`timescale 1ns/1ps
`include "if_cfg.svh"

module tb_if_stage import if_pkg::*; ();

  localparam int ClkPeriod  = 4;
  localparam int NumRows    = 9;
  localparam int RowCycles  = 200;
  localparam int IdleCycles = 16;
  localparam int WatchdogNs = (NumRows * RowCycles + 10) * ClkPeriod;
  localparam logic [31:0] DataKey = 32'h1357_9bdf;
  localparam logic [31:0] ErrLo   = 32'h0000_6000;
  localparam logic [31:0] ErrHi   = 32'h0000_6008;

  // one redirect scenario with its expected first pc
  typedef struct packed {
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_sel;
    irq_id_t     irq_id;
    logic [31:0] operand;
    logic [7:0]  count;
    logic [7:0]  stall_pct;
    logic [31:0] exp_pc;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_i;
  redirect_t   redirect_i;
  csr_pc_t     csr_pc_i;
  logic        csr_mtvec_init_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic [31:0] wb_adr_o;
  logic        wb_we_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;
  logic        wb_err_i;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  logic [31:0] instr_rdata_id_o;
  logic        instr_fetch_err_o;
  logic [31:0] pc_id_o;
  logic [31:0] pc_if_o;
  logic        if_busy_o;

  row_t        rows [NumRows];
  logic [31:0] stall_lcg;
  int          err_count;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  if_stage if_stage_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .redirect_i          (redirect_i),
    .csr_pc_i            (csr_pc_i),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .wb_cyc_o            (wb_cyc_o),
    .wb_stb_o            (wb_stb_o),
    .wb_adr_o            (wb_adr_o),
    .wb_we_o             (wb_we_o),
    .wb_dat_i            (wb_dat_i),
    .wb_ack_i            (wb_ack_i),
    .wb_err_i            (wb_err_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .if_busy_o           (if_busy_o)
  );

  wb_mem_model #(.ERR_LO(ErrLo), .ERR_HI(ErrHi)) mem_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_adr_i (wb_adr_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack_o (wb_ack_i),
    .wb_err_o (wb_err_i)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // ready is low with the given percentage
  function automatic logic roll_ready(input logic [7:0] pct);
    stall_lcg = lcg_next(stall_lcg);
    return (stall_lcg[31:16] % 16'd100) >= pct;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ErrLo) && (addr < ErrHi);
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string name);
    if (actual !== expected) begin
      err_count++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual,
               expected);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // redirect, collect the stream, then clear and back-pressure
  task automatic apply_row(input int idx);
    row_t        row;
    logic [31:0] exp_pc;
    int          got;
    logic        adr_stale;
    logic        adr_checked;
    row    = rows[idx];
    exp_pc = row.exp_pc;
    got    = 0;
    // odd rows free one slot and redirect while that fetch is on the bus
    if (idx % 2 == 1) begin
      id_in_ready_i = 1'b1;
      @(negedge clk_i);
      id_in_ready_i = 1'b0;
      while (!wb_cyc_o) begin
        @(negedge clk_i);
      end
    end
    // operands no row expects, so a wrong mux leg shows up
    csr_pc_i = '{boot_addr: 32'h0bad_0000, mtvec: 32'h0bad_1100, mepc: 32'h0bad_2200,
                 depc: 32'h0bad_3300, jump_target: 32'h0bad_4400};
    case (row.pc_sel)
      PC_BOOT: csr_pc_i.boot_addr   = row.operand;
      PC_JUMP: csr_pc_i.jump_target = row.operand;
      PC_EXC:  csr_pc_i.mtvec       = row.operand;
      PC_ERET: csr_pc_i.mepc        = row.operand;
      default: csr_pc_i.depc        = row.operand;
    endcase
    redirect_i = '{set: 1'b1, pc_sel: row.pc_sel, exc_sel: row.exc_sel, irq_id: row.irq_id};
    req_i               = 1'b1;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = roll_ready(row.stall_pct);
    // a request already up belongs to the old stream
    adr_stale   = wb_stb_o;
    adr_checked = 1'b0;
    #1;
    check(csr_mtvec_init_o, row.pc_sel == PC_BOOT, "csr_mtvec_init_o");
    while (got < row.count) begin
      @(negedge clk_i);
      redirect_i.set = 1'b0;
      // first request after the redirect carries the new address
      if (!wb_stb_o) begin
        adr_stale = 1'b0;
      end else if (!adr_stale && !adr_checked) begin
        check(wb_adr_o, row.exp_pc, "wb_adr_o");
        adr_checked = 1'b1;
      end
      if (instr_new_id_o) begin
        // ready still holds the value seen at the accepting edge
        check(id_in_ready_i, 1, "id_in_ready_i");
        check(instr_valid_id_o, 1, "instr_valid_id_o");
        check(pc_id_o, exp_pc, "pc_id_o");
        check(instr_rdata_id_o, exp_pc ^ DataKey, "instr_rdata_id_o");
        check(instr_fetch_err_o, in_err_window(exp_pc), "instr_fetch_err_o");
        check(wb_we_o, 0, "wb_we_o");
        exp_pc = exp_pc + 32'd4;
        got++;
      end else if (got > 0) begin
        check(instr_valid_id_o, 1, "instr_valid_id_o");
      end
      id_in_ready_i = roll_ready(row.stall_pct);
    end
    // clear with no acceptance drops valid
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    check(instr_new_id_o, 0, "instr_new_id_o");
    check(instr_valid_id_o, 0, "instr_valid_id_o");
    instr_valid_clear_i = 1'b0;
    // full buffer stops the bus, head is the next sequential word
    repeat (IdleCycles) @(negedge clk_i);
    check(wb_cyc_o, 0, "wb_cyc_o");
    check(if_busy_o, 0, "if_busy_o");
    check(pc_if_o, exp_pc, "pc_if_o");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    redirect_i          = '0;
    csr_pc_i            = '0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    stall_lcg           = 32'he4494fd6;
    err_count           = 0;
    // pc_sel, exc_sel, irq, operand, count, stall %, first pc
    rows[0] = '{PC_BOOT, EXC_PC_EXC, 5'd0, 32'h0000_1000, 8'd6, 8'd0, 32'h0000_1080};
    rows[1] = '{PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_2003, 8'd5, 8'd30, 32'h0000_2000};
    rows[2] = '{PC_EXC, EXC_PC_EXC, 5'd0, 32'h0000_3045, 8'd4, 8'd0, 32'h0000_3000};
    rows[3] = '{PC_EXC, EXC_PC_IRQ, 5'd7, 32'h0000_3001, 8'd4, 8'd50, 32'h0000_301c};
    rows[4] = '{PC_EXC, EXC_PC_DBD, 5'd0, 32'h0000_3000, 8'd3, 8'd20, `IF_DM_HALT_ADDR};
    rows[5] = '{PC_EXC, EXC_PC_DBG_EXC, 5'd0, 32'h0000_3000, 8'd3, 8'd0, `IF_DM_EXC_ADDR};
    rows[6] = '{PC_ERET, EXC_PC_EXC, 5'd0, 32'h0000_4006, 8'd5, 8'd60, 32'h0000_4004};
    rows[7] = '{PC_DRET, EXC_PC_EXC, 5'd0, 32'h0000_5ffe, 8'd6, 8'd40, 32'h0000_5ffc};
    rows[8] = '{PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_7000, 8'd8, 8'd70, 32'h0000_7000};
    repeat (2) @(negedge clk_i);
    // outputs idle while in reset
    check(wb_cyc_o, 0, "wb_cyc_o");
    check(wb_stb_o, 0, "wb_stb_o");
    check(instr_valid_id_o, 0, "instr_valid_id_o");
    check(instr_new_id_o, 0, "instr_new_id_o");
    check(csr_mtvec_init_o, 0, "csr_mtvec_init_o");
    check(if_busy_o, 0, "if_busy_o");
    rst_ni = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      apply_row(i);
    end
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // hang guard sized from the table
  initial begin
    #(WatchdogNs);
    $display("timeout: instruction stream did not finish within %0d cycles per row",
             RowCycles);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- bench/wb_mem_model.sv
//////////////////////////////
// wishbone classic read slave
// data is address xor a fixed key
// random wait states, error window
//////////////////////////////
`timescale 1ns/1ps

module wb_mem_model #(
  parameter logic [31:0] ERR_LO = 32'h0,
  parameter logic [31:0] ERR_HI = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o
);

  localparam logic [31:0] DataKey = 32'h1357_9bdf;

  logic [31:0] lcg_q;
  logic [1:0]  wait_q;
  logic [1:0]  delay_q;

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcg_q    <= 32'he4494fd6;
      wait_q   <= '0;
      delay_q  <= '0;
      wb_dat_o <= '0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else if (wb_ack_o || wb_err_o) begin
      // response lasts one cycle, then draw the next wait count
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wait_q   <= '0;
      lcg_q    <= lcg_next(lcg_q);
      delay_q  <= lcg_q[31:30];
    end else if (wb_cyc_i && wb_stb_i) begin
      if (wait_q == delay_q) begin
        wb_dat_o <= wb_adr_i ^ DataKey;
        // error window answers with err instead of ack
        if (wb_adr_i >= ERR_LO && wb_adr_i < ERR_HI) begin
          wb_err_o <= 1'b1;
        end else begin
          wb_ack_o <= 1'b1;
        end
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

endmodule

//--- verilog/if_stage.sv
//////////////////////////////
// instruction fetch stage top
// address select, bus master, buffer, IF-ID register
//////////////////////////////
`timescale 1ns/1ps
`include "if_cfg.svh"

module if_stage import if_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  redirect_t           redirect_i,
  input  csr_pc_t             csr_pc_i,
  output logic                csr_mtvec_init_o,
  // wishbone classic fetch port
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic [`IF_XLEN-1:0] wb_adr_o,
  output logic                wb_we_o,
  input  logic [`IF_XLEN-1:0] wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  // decode side
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [`IF_XLEN-1:0] instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output logic [`IF_XLEN-1:0] pc_id_o,
  output logic [`IF_XLEN-1:0] pc_if_o,
  output logic                if_busy_o
);

  logic [`IF_XLEN-1:0] redirect_addr;
  logic                redirect;
  logic                slot_free;
  logic                push;
  fetch_entry_t        push_entry;
  logic                head_valid;
  fetch_entry_t        head_entry;
  logic                pop;

  pc_select pc_select_inst (
    .redirect_i       (redirect_i),
    .csr_pc_i         (csr_pc_i),
    .fetch_addr_o     (redirect_addr),
    .redirect_o       (redirect),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  wb_fetch wb_fetch_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .redirect_i      (redirect),
    .redirect_addr_i (redirect_addr),
    .slot_free_i     (slot_free),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .wb_adr_o        (wb_adr_o),
    .wb_we_o         (wb_we_o),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_i        (wb_ack_i),
    .wb_err_i        (wb_err_i),
    .push_o          (push),
    .push_entry_o    (push_entry),
    .busy_o          (if_busy_o)
  );

  // redirect empties the buffer
  fetch_buffer fetch_buffer_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (redirect),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .slot_free_o  (slot_free),
    .head_valid_o (head_valid),
    .head_entry_o (head_entry)
  );

  if_id_reg if_id_reg_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .head_valid_i        (head_valid),
    .head_entry_i        (head_entry),
    .id_in_ready_i       (id_in_ready_i),
    .redirect_i          (redirect),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pop_o               (pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o)
  );

endmodule

//--- verilog/if_id_reg.sv
//////////////////////////////
// IF-ID pipeline register
// accept, valid hold and new pulse
//////////////////////////////
`timescale 1ns/1ps
`include "if_cfg.svh"

module if_id_reg import if_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                head_valid_i,
  input  fetch_entry_t        head_entry_i,
  input  logic                id_in_ready_i,
  input  logic                redirect_i,
  input  logic                instr_valid_clear_i,
  output logic                pop_o,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [`IF_XLEN-1:0] instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output logic [`IF_XLEN-1:0] pc_id_o,
  output logic [`IF_XLEN-1:0] pc_if_o
);

  logic accept;
  logic valid_q;
  logic new_q;

  // a redirect squashes the word at the buffer head
  assign accept = head_valid_i & id_in_ready_i & ~redirect_i;
  assign pop_o  = accept;

  // address of the word waiting in IF
  assign pc_if_o = head_entry_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      // valid sticks until ID clears it
      valid_q <= accept | (valid_q & ~instr_valid_clear_i);
      // single cycle marker per accepted word
      new_q   <= accept;
    end
  end

  // payload frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_rdata_id_o  <= head_entry_i.instr;
      instr_fetch_err_o <= head_entry_i.err;
      pc_id_o           <= head_entry_i.addr;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

//--- verilog/fetch_buffer.sv
//////////////////////////////
// fetched word fifo
// circular storage with occupancy count and flush
//////////////////////////////
`timescale 1ns/1ps
`include "if_cfg.svh"

module fetch_buffer import if_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         push_i,
  input  fetch_entry_t push_entry_i,
  input  logic         pop_i,
  output logic         slot_free_o,
  output logic         head_valid_o,
  output fetch_entry_t head_entry_o
);

  localparam int Depth = `IF_FB_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);
  localparam logic [PtrW-1:0] LastIdx = PtrW'(Depth - 1);
  localparam logic [CntW-1:0] FullCnt = CntW'(Depth);

  fetch_entry_t    mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  // wrap at the last entry for any depth
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == LastIdx) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect discards every buffered word
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // the fetcher starts only with nothing in flight
  // so a free slot here is the slot the next transfer lands in
  assign slot_free_o  = (count_q < FullCnt);
  assign head_valid_o = (count_q != '0);
  assign head_entry_o = mem_q[rd_ptr_q];

  //////////////////////////////
  // assertions
  //////////////////////////////

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    push_i |-> (count_q < FullCnt));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    pop_i |-> (count_q != '0));

endmodule

//--- verilog/wb_fetch.sv
//////////////////////////////
// wishbone classic fetch master
// fetch pc, squash of stale responses
//////////////////////////////
`timescale 1ns/1ps
`include "if_cfg.svh"

module wb_fetch import if_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                redirect_i,
  input  logic [`IF_XLEN-1:0] redirect_addr_i,
  input  logic                slot_free_i,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic [`IF_XLEN-1:0] wb_adr_o,
  output logic                wb_we_o,
  input  logic [`IF_XLEN-1:0] wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  output logic                push_o,
  output fetch_entry_t        push_entry_o,
  output logic                busy_o
);

  localparam logic [`IF_XLEN-1:0] WordStep = 4;

  typedef enum logic {
    IDLE,
    BUS
  } fetch_state_e;

  fetch_state_e        state_q, state_d;
  logic [`IF_XLEN-1:0] pc_q, pc_d;
  logic [`IF_XLEN-1:0] adr_q;
  logic                squash_q, squash_d;
  logic                bus_done;
  logic                start;
  logic [`IF_XLEN-1:0] start_addr;

  // ack or err closes the transfer
  assign bus_done = (state_q == BUS) & (wb_ack_i | wb_err_i);

  // a redirect flushes the buffer on the same edge so room is guaranteed
  assign start      = (state_q == IDLE) & req_i & (slot_free_i | redirect_i);
  assign start_addr = redirect_i ? redirect_addr_i : pc_q;

  // stale words are dropped, also when the redirect meets the ack
  assign push_o = bus_done & ~squash_q & ~redirect_i;

  always_comb begin
    state_d  = state_q;
    pc_d     = pc_q;
    squash_d = squash_q;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_d = BUS;
        end
      end
      BUS: begin
        if (bus_done) begin
          state_d  = IDLE;
          squash_d = 1'b0;
        end else if (redirect_i) begin
          // let the pending cycle finish on the bus
          squash_d = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
    // next sequential word after each kept transfer
    if (redirect_i) begin
      pc_d = redirect_addr_i;
    end else if (push_o) begin
      pc_d = adr_q + WordStep;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      pc_q     <= '0;
      squash_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      pc_q     <= pc_d;
      squash_q <= squash_d;
    end
  end

  // bus address held for the whole cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= start_addr;
    end
  end

  assign wb_cyc_o = (state_q == BUS);
  assign wb_stb_o = (state_q == BUS);
  assign wb_adr_o = adr_q;
  assign wb_we_o  = 1'b0;
  assign busy_o   = (state_q == BUS);

  assign push_entry_o = '{instr: wb_dat_i, addr: adr_q, err: wb_err_i};

  //////////////////////////////
  // assertions
  //////////////////////////////

  // request address is known and word aligned
  a_adr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> (!$isunknown(wb_adr_o) && wb_adr_o[1:0] == 2'b00));

endmodule

//--- verilog/pc_select.sv
//////////////////////////////
// next fetch address selection
// trap vector mux and mtvec init pulse
//////////////////////////////
`timescale 1ns/1ps
`include "if_cfg.svh"

module pc_select import if_pkg::*; (
  input  redirect_t           redirect_i,
  input  csr_pc_t             csr_pc_i,
  output logic [`IF_XLEN-1:0] fetch_addr_o,
  output logic                redirect_o,
  output logic                csr_mtvec_init_o
);

  localparam int VecLsb = `IF_VEC_ALIGN_BITS;
  localparam int OffW   = $bits(`IF_BOOT_OFFSET);

  logic [`IF_XLEN-1:0] mtvec_base;
  logic [`IF_XLEN-1:0] irq_offset;
  logic [`IF_XLEN-1:0] exc_pc;

  // handler base with the low bits cleared
  assign mtvec_base = {csr_pc_i.mtvec[`IF_XLEN-1:VecLsb], {VecLsb{1'b0}}};
  // one word per interrupt line
  assign irq_offset = `IF_XLEN'({redirect_i.irq_id, 2'b00});

  always_comb begin
    case (redirect_i.exc_sel)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  // all targets are forced onto a word boundary
  always_comb begin
    case (redirect_i.pc_sel)
      PC_BOOT: fetch_addr_o = {csr_pc_i.boot_addr[`IF_XLEN-1:OffW], `IF_BOOT_OFFSET};
      PC_JUMP: fetch_addr_o = {csr_pc_i.jump_target[`IF_XLEN-1:2], 2'b00};
      PC_EXC:  fetch_addr_o = exc_pc;
      PC_ERET: fetch_addr_o = {csr_pc_i.mepc[`IF_XLEN-1:2], 2'b00};
      PC_DRET: fetch_addr_o = {csr_pc_i.depc[`IF_XLEN-1:2], 2'b00};
      default: fetch_addr_o = {csr_pc_i.boot_addr[`IF_XLEN-1:OffW], `IF_BOOT_OFFSET};
    endcase
  end

  assign redirect_o = redirect_i.set;

  // csr file loads mtvec from the boot address in the same cycle
  assign csr_mtvec_init_o = redirect_i.set & (redirect_i.pc_sel == PC_BOOT);

  //////////////////////////////
  // assertions
  //////////////////////////////

  // a redirect must name a known source
  always_comb begin
    if (redirect_i.set) begin
      assert final (redirect_i.pc_sel inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET})
        else $error("pc_sel %0d not a known redirect source", redirect_i.pc_sel);
    end
  end

endmodule

//--- verilog/if_pkg.sv
//////////////////////////////
// fetch stage shared types
// redirect control, csr operands, buffer entry
//////////////////////////////
`include "if_cfg.svh"

package if_pkg;

  // source of a new fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // kind of trap handler entry
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // interrupt number for vectored entry
  typedef logic [4:0] irq_id_t;

  // redirect request from the controller
  typedef struct packed {
    logic        set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_sel;
    irq_id_t     irq_id;
  } redirect_t;

  // csr and target operands of the address mux
  typedef struct packed {
    logic [`IF_XLEN-1:0] boot_addr;
    logic [`IF_XLEN-1:0] mtvec;
    logic [`IF_XLEN-1:0] mepc;
    logic [`IF_XLEN-1:0] depc;
    logic [`IF_XLEN-1:0] jump_target;
  } csr_pc_t;

  // one fetched word with its address and bus error flag
  typedef struct packed {
    logic [`IF_XLEN-1:0] instr;
    logic [`IF_XLEN-1:0] addr;
    logic                err;
  } fetch_entry_t;

endpackage

//--- verilog/if_cfg.svh
//////////////////////////////
// fetch stage configuration macros
// widths, boot offset, debug entry points, buffer depth
//////////////////////////////
`ifndef IF_CFG_SVH
`define IF_CFG_SVH

// address and instruction word width
`define IF_XLEN 32

// low byte placed on the boot base
`define IF_BOOT_OFFSET 8'h80

// number of low mtvec bits cleared for the handler base
`define IF_VEC_ALIGN_BITS 8

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR 32'h1A11_0808

// fetch buffer entries
`define IF_FB_DEPTH 2

`endif
